//--- src/fabric_settings.svh
`ifndef FABRIC_SETTINGS_SVH
`define FABRIC_SETTINGS_SVH

// Cluster count and index width
`define NUM_CLUSTERS        4
`define CLUSTER_BITS        2

// I/O request shape
`define NUM_THREADS         2
`define IO_ADDR_WIDTH       30
`define IO_DATA_WIDTH       32
`define IO_BYTEEN_WIDTH     4

// Memory tag carries the cluster index on top
`define CLUSTER_TAG_WIDTH   8
`define MEM_TAG_WIDTH       10

// CSR access from the host
`define CSR_ID_WIDTH        4
`define LOCAL_ID_WIDTH      2
`define CSR_ADDR_WIDTH      12

`endif

//--- src/fabric_pkg.sv
`include "fabric_settings.svh"

package fabric_pkg;

    // Request as issued by one cluster
    typedef struct packed {
        logic                                               rw;
        logic [`NUM_THREADS-1:0][`IO_BYTEEN_WIDTH-1:0]      byteen;
        logic [`NUM_THREADS-1:0][`IO_ADDR_WIDTH-1:0]        addr;
        logic [`NUM_THREADS-1:0][`IO_DATA_WIDTH-1:0]        data;
        logic [`CLUSTER_TAG_WIDTH-1:0]                      tag;
    } cluster_io_req_t;

    // Same request on the shared memory side
    typedef struct packed {
        logic                                               rw;
        logic [`NUM_THREADS-1:0][`IO_BYTEEN_WIDTH-1:0]      byteen;
        logic [`NUM_THREADS-1:0][`IO_ADDR_WIDTH-1:0]        addr;
        logic [`NUM_THREADS-1:0][`IO_DATA_WIDTH-1:0]        data;
        logic [`MEM_TAG_WIDTH-1:0]                          tag;
    } mem_io_req_t;

    typedef struct packed {
        logic [`IO_DATA_WIDTH-1:0]      data;
        logic [`MEM_TAG_WIDTH-1:0]      tag;
    } mem_io_rsp_t;

    typedef struct packed {
        logic [`IO_DATA_WIDTH-1:0]      data;
        logic [`CLUSTER_TAG_WIDTH-1:0]  tag;
    } cluster_io_rsp_t;

    // Core id travels beside this struct
    typedef struct packed {
        logic [`CSR_ADDR_WIDTH-1:0]     addr;
        logic                           rw;
        logic [31:0]                    data;
    } csr_req_t;

endpackage

//--- src/io_arb.sv
`timescale 1ns/10ps
`include "fabric_settings.svh"

module io_arb (
    input  logic                                            clk,
    input  logic                                            arst_n,

    // Cluster requests
    input  logic [`NUM_CLUSTERS-1:0][`NUM_THREADS-1:0]      cl_io_req_valid,
    input  fabric_pkg::cluster_io_req_t [`NUM_CLUSTERS-1:0] cl_io_req,
    output logic [`NUM_CLUSTERS-1:0]                        cl_io_req_ready,

    // Memory side request
    output logic [`NUM_THREADS-1:0]                         mem_io_req_valid,
    output fabric_pkg::mem_io_req_t                         mem_io_req,
    input  logic                                            mem_io_req_ready,

    // Memory side response
    input  logic                                            mem_io_rsp_valid,
    input  fabric_pkg::mem_io_rsp_t                         mem_io_rsp,
    output logic                                            mem_io_rsp_ready,

    // Cluster responses
    output logic [`NUM_CLUSTERS-1:0]                        cl_io_rsp_valid,
    output fabric_pkg::cluster_io_rsp_t                     cl_io_rsp,
    input  logic [`NUM_CLUSTERS-1:0]                        cl_io_rsp_ready
);
    import fabric_pkg::*;

    logic [`NUM_CLUSTERS-1:0]   req_any;
    logic                       grant_found;
    logic [`CLUSTER_BITS-1:0]   grant_idx;
    logic [`CLUSTER_BITS-1:0]   scan_idx;
    logic [`CLUSTER_BITS-1:0]   rr_ptr;

    logic                       slot_free;
    logic                       slot_load;
    logic [`NUM_THREADS-1:0]    slot_valid;
    mem_io_req_t                slot_req;

    cluster_io_req_t            win_req;
    mem_io_req_t                win_req_ext;
    logic [`CLUSTER_BITS-1:0]   rsp_cluster;

    // A cluster requests when any lane is valid
    for (genvar i = 0; i < `NUM_CLUSTERS; i++) begin : g_req
        assign req_any[i] = |cl_io_req_valid[i];
    end

    // Rotating priority, search starts at rr_ptr
    always_comb begin
        grant_found = 1'b0;
        grant_idx   = '0;
        scan_idx    = rr_ptr;
        for (int k = 0; k < `NUM_CLUSTERS; k++) begin
            scan_idx = `CLUSTER_BITS'((int'(rr_ptr) + k) % `NUM_CLUSTERS);
            if (!grant_found && req_any[scan_idx]) begin
                grant_found = 1'b1;
                grant_idx   = scan_idx;
            end
        end
    end

    // Slot takes a new entry when empty or emptying this cycle
    assign slot_free = !(|slot_valid) || mem_io_req_ready;
    assign slot_load = slot_free && grant_found;

    for (genvar i = 0; i < `NUM_CLUSTERS; i++) begin : g_ready
        assign cl_io_req_ready[i] = slot_free && grant_found
                                    && (grant_idx == `CLUSTER_BITS'(i));
    end

    // Prepend the cluster index to the tag
    always_comb begin
        win_req            = cl_io_req[grant_idx];
        win_req_ext.rw     = win_req.rw;
        win_req_ext.byteen = win_req.byteen;
        win_req_ext.addr   = win_req.addr;
        win_req_ext.data   = win_req.data;
        win_req_ext.tag    = {grant_idx, win_req.tag};
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            slot_valid <= '0;
            rr_ptr     <= '0;
        end else begin
            if (slot_load) begin
                slot_valid <= cl_io_req_valid[grant_idx];
                rr_ptr     <= (grant_idx == `CLUSTER_BITS'(`NUM_CLUSTERS - 1)) ?
                              '0 : grant_idx + 1'b1;
            end else if (mem_io_req_ready) begin
                slot_valid <= '0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (slot_load) begin
            slot_req <= win_req_ext;
        end
    end

    assign mem_io_req_valid = slot_valid;
    assign mem_io_req       = slot_req;

    // Response goes back by the index in the upper tag bits
    assign rsp_cluster = mem_io_rsp.tag[`MEM_TAG_WIDTH-1 -: `CLUSTER_BITS];

    for (genvar i = 0; i < `NUM_CLUSTERS; i++) begin : g_rsp
        assign cl_io_rsp_valid[i] = mem_io_rsp_valid
                                    && (rsp_cluster == `CLUSTER_BITS'(i));
    end

    assign cl_io_rsp = '{
        data: mem_io_rsp.data,
        tag:  mem_io_rsp.tag[`CLUSTER_TAG_WIDTH-1:0]
    };

    assign mem_io_rsp_ready = cl_io_rsp_ready[rsp_cluster];

endmodule

//--- src/csr_io_router.sv
`timescale 1ns/10ps
`include "fabric_settings.svh"

module csr_io_router (
    input  logic                                    clk,
    input  logic                                    arst_n,

    // Host request
    input  logic                                    csr_req_valid,
    input  logic [`CSR_ID_WIDTH-1:0]                csr_req_coreid,
    input  fabric_pkg::csr_req_t                    csr_req,
    output logic                                    csr_req_ready,

    // Cluster requests
    output logic [`NUM_CLUSTERS-1:0]                cl_csr_req_valid,
    output fabric_pkg::csr_req_t                    cl_csr_req,
    output logic [`LOCAL_ID_WIDTH-1:0]              cl_csr_coreid,
    input  logic [`NUM_CLUSTERS-1:0]                cl_csr_req_ready,

    // Cluster responses
    input  logic [`NUM_CLUSTERS-1:0]                cl_csr_rsp_valid,
    input  logic [`NUM_CLUSTERS-1:0][31:0]          cl_csr_rsp_data,
    output logic [`NUM_CLUSTERS-1:0]                cl_csr_rsp_ready,

    // Host response
    output logic                                    csr_rsp_valid,
    output logic [31:0]                             csr_rsp_data,
    input  logic                                    csr_rsp_ready
);

    logic [`CLUSTER_BITS-1:0]   req_sel;
    logic [`CLUSTER_BITS-1:0]   rsp_sel;
    logic                       busy;
    logic                       req_fire;
    logic                       rsp_fire;

    // Upper core id bits pick the cluster
    assign req_sel       = csr_req_coreid[`LOCAL_ID_WIDTH +: `CLUSTER_BITS];
    assign cl_csr_coreid = csr_req_coreid[`LOCAL_ID_WIDTH-1:0];
    assign cl_csr_req    = csr_req;

    for (genvar i = 0; i < `NUM_CLUSTERS; i++) begin : g_req
        assign cl_csr_req_valid[i] = csr_req_valid && !busy
                                     && (req_sel == `CLUSTER_BITS'(i));
    end

    assign csr_req_ready = !busy && cl_csr_req_ready[req_sel];
    assign req_fire      = csr_req_valid && csr_req_ready;

    // Only the cluster that took the request may answer
    assign csr_rsp_valid = busy && cl_csr_rsp_valid[rsp_sel];
    assign csr_rsp_data  = cl_csr_rsp_data[rsp_sel];
    assign rsp_fire      = csr_rsp_valid && csr_rsp_ready;

    for (genvar i = 0; i < `NUM_CLUSTERS; i++) begin : g_rsp
        assign cl_csr_rsp_ready[i] = busy && csr_rsp_ready
                                     && (rsp_sel == `CLUSTER_BITS'(i));
    end

    // One request in flight
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy    <= 1'b0;
            rsp_sel <= '0;
        end else begin
            if (req_fire) begin
                busy    <= 1'b1;
                rsp_sel <= req_sel;
            end else if (rsp_fire) begin
                busy    <= 1'b0;
            end
        end
    end

endmodule

//--- src/fabric_top.sv
`timescale 1ns/10ps
`include "fabric_settings.svh"

module fabric_top (
    input  logic                                            clk,
    input  logic                                            arst_n,

    // Cluster I/O
    input  logic [`NUM_CLUSTERS-1:0][`NUM_THREADS-1:0]      cl_io_req_valid,
    input  fabric_pkg::cluster_io_req_t [`NUM_CLUSTERS-1:0] cl_io_req,
    output logic [`NUM_CLUSTERS-1:0]                        cl_io_req_ready,
    output logic [`NUM_CLUSTERS-1:0]                        cl_io_rsp_valid,
    output fabric_pkg::cluster_io_rsp_t                     cl_io_rsp,
    input  logic [`NUM_CLUSTERS-1:0]                        cl_io_rsp_ready,

    // Memory side I/O
    output logic [`NUM_THREADS-1:0]                         mem_io_req_valid,
    output fabric_pkg::mem_io_req_t                         mem_io_req,
    input  logic                                            mem_io_req_ready,
    input  logic                                            mem_io_rsp_valid,
    input  fabric_pkg::mem_io_rsp_t                         mem_io_rsp,
    output logic                                            mem_io_rsp_ready,

    // Host CSR
    input  logic                                            csr_req_valid,
    input  logic [`CSR_ID_WIDTH-1:0]                        csr_req_coreid,
    input  fabric_pkg::csr_req_t                            csr_req,
    output logic                                            csr_req_ready,
    output logic                                            csr_rsp_valid,
    output logic [31:0]                                     csr_rsp_data,
    input  logic                                            csr_rsp_ready,

    // Cluster CSR
    output logic [`NUM_CLUSTERS-1:0]                        cl_csr_req_valid,
    output fabric_pkg::csr_req_t                            cl_csr_req,
    output logic [`LOCAL_ID_WIDTH-1:0]                      cl_csr_coreid,
    input  logic [`NUM_CLUSTERS-1:0]                        cl_csr_req_ready,
    input  logic [`NUM_CLUSTERS-1:0]                        cl_csr_rsp_valid,
    input  logic [`NUM_CLUSTERS-1:0][31:0]                  cl_csr_rsp_data,
    output logic [`NUM_CLUSTERS-1:0]                        cl_csr_rsp_ready,

    // Status
    input  logic [`NUM_CLUSTERS-1:0]                        cl_busy,
    input  logic [`NUM_CLUSTERS-1:0]                        cl_ebreak,
    output logic                                            busy,
    output logic                                            ebreak
);

    io_arb u_io_arb (
        .clk              (clk),
        .arst_n           (arst_n),
        .cl_io_req_valid  (cl_io_req_valid),
        .cl_io_req        (cl_io_req),
        .cl_io_req_ready  (cl_io_req_ready),
        .mem_io_req_valid (mem_io_req_valid),
        .mem_io_req       (mem_io_req),
        .mem_io_req_ready (mem_io_req_ready),
        .mem_io_rsp_valid (mem_io_rsp_valid),
        .mem_io_rsp       (mem_io_rsp),
        .mem_io_rsp_ready (mem_io_rsp_ready),
        .cl_io_rsp_valid  (cl_io_rsp_valid),
        .cl_io_rsp        (cl_io_rsp),
        .cl_io_rsp_ready  (cl_io_rsp_ready)
    );

    csr_io_router u_csr_io_router (
        .clk              (clk),
        .arst_n           (arst_n),
        .csr_req_valid    (csr_req_valid),
        .csr_req_coreid   (csr_req_coreid),
        .csr_req          (csr_req),
        .csr_req_ready    (csr_req_ready),
        .cl_csr_req_valid (cl_csr_req_valid),
        .cl_csr_req       (cl_csr_req),
        .cl_csr_coreid    (cl_csr_coreid),
        .cl_csr_req_ready (cl_csr_req_ready),
        .cl_csr_rsp_valid (cl_csr_rsp_valid),
        .cl_csr_rsp_data  (cl_csr_rsp_data),
        .cl_csr_rsp_ready (cl_csr_rsp_ready),
        .csr_rsp_valid    (csr_rsp_valid),
        .csr_rsp_data     (csr_rsp_data),
        .csr_rsp_ready    (csr_rsp_ready)
    );

    // Busy if any cluster is, halted only when all are
    assign busy   = |cl_busy;
    assign ebreak = &cl_ebreak;

endmodule

//--- verification/tb_clock_gen.sv
`timescale 1ns/10ps

module tb_clock_gen (
    output logic clk,
    output logic arst_n
);

    // 8 ns period
    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        arst_n = 1'b0;
        repeat (2) @(posedge clk);
        #1 arst_n = 1'b1;
    end

endmodule

//--- verification/tb_fabric.sv
`timescale 1ns/10ps
`include "fabric_settings.svh"

module tb_fabric;
    import fabric_pkg::*;

    localparam int NUM_ENTRIES = 10;
    localparam int TIMEOUT     = 200;
    localparam int CW          = 160;

    localparam logic [1:0] KIND_IO     = 2'd0;
    localparam logic [1:0] KIND_RSP    = 2'd1;
    localparam logic [1:0] KIND_CSR    = 2'd2;
    localparam logic [1:0] KIND_STATUS = 2'd3;

    // exp_order holds cluster indices with the first grant in the low bits
    typedef struct packed {
        logic [1:0]     kind;
        logic [3:0]     mask;
        logic [3:0]     aux;
        logic [1:0]     lanes;
        logic [29:0]    addr;
        logic [7:0]     tag;
        logic [3:0]     coreid;
        logic           stall;
        logic [2:0]     exp_cnt;
        logic [7:0]     exp_order;
        logic [31:0]    exp_data;
    } entry_t;

    logic                                       clk;
    logic                                       arst_n;
    logic [`NUM_CLUSTERS-1:0][`NUM_THREADS-1:0] cl_io_req_valid;
    cluster_io_req_t [`NUM_CLUSTERS-1:0]        cl_io_req;
    logic [`NUM_CLUSTERS-1:0]                   cl_io_req_ready;
    logic [`NUM_CLUSTERS-1:0]                   cl_io_rsp_valid;
    cluster_io_rsp_t                            cl_io_rsp;
    logic [`NUM_CLUSTERS-1:0]                   cl_io_rsp_ready;
    logic [`NUM_THREADS-1:0]                    mem_io_req_valid;
    mem_io_req_t                                mem_io_req;
    logic                                       mem_io_req_ready;
    logic                                       mem_io_rsp_valid;
    mem_io_rsp_t                                mem_io_rsp;
    logic                                       mem_io_rsp_ready;
    logic                                       csr_req_valid;
    logic [`CSR_ID_WIDTH-1:0]                   csr_req_coreid;
    csr_req_t                                   csr_req;
    logic                                       csr_req_ready;
    logic                                       csr_rsp_valid;
    logic [31:0]                                csr_rsp_data;
    logic                                       csr_rsp_ready;
    logic [`NUM_CLUSTERS-1:0]                   cl_csr_req_valid;
    csr_req_t                                   cl_csr_req;
    logic [`LOCAL_ID_WIDTH-1:0]                 cl_csr_coreid;
    logic [`NUM_CLUSTERS-1:0]                   cl_csr_req_ready;
    logic [`NUM_CLUSTERS-1:0]                   cl_csr_rsp_valid;
    logic [`NUM_CLUSTERS-1:0][31:0]             cl_csr_rsp_data;
    logic [`NUM_CLUSTERS-1:0]                   cl_csr_rsp_ready;
    logic [`NUM_CLUSTERS-1:0]                   cl_busy;
    logic [`NUM_CLUSTERS-1:0]                   cl_ebreak;
    logic                                       busy;
    logic                                       ebreak;

    entry_t         tbl [NUM_ENTRIES];
    mem_io_req_t    exp_req [`NUM_CLUSTERS];
    string          kind_name [4] = '{"io", "rsp", "csr", "status"};
    integer         seed;
    int             errors;
    int             tests_failed;

    tb_clock_gen u_clk_gen (
        .clk    (clk),
        .arst_n (arst_n)
    );

    fabric_top u_dut (.*);

    task automatic report_mismatch(input string name, input logic [CW-1:0] got,
                                   input logic [CW-1:0] exp);
        $display("CHECK FAILED at %0t ns: %s got %0h expected %0h", $time, name, got, exp);
        errors++;
    endtask

    task automatic report_error(input string msg);
        $display("ERROR at %0t ns: %s", $time, msg);
        errors++;
    endtask

    task automatic run_io(input entry_t e);
        logic [3:0]     pending;
        int             n_in;
        int             n_out;
        int             last_acc;
        int             cycles;
        logic           held;
        mem_io_req_t    held_req;
        pending  = e.mask;
        n_in     = 0;
        n_out    = 0;
        last_acc = -1;
        cycles   = 0;
        held     = 1'b0;
        held_req = '0;
        for (int i = 0; i < `NUM_CLUSTERS; i++) begin
            exp_req[i].rw     = 1'(i);
            exp_req[i].byteen = {4'hf, 4'(i + 1)};
            exp_req[i].addr   = {e.addr + 30'(i), e.addr + 30'(i + 8)};
            exp_req[i].data   = {32'($random(seed)), 32'($random(seed))};
            exp_req[i].tag    = {2'(i), e.tag + 8'(i)};
            cl_io_req[i]      = '{exp_req[i].rw, exp_req[i].byteen, exp_req[i].addr,
                                  exp_req[i].data, exp_req[i].tag[7:0]};
            cl_io_req_valid[i] = pending[i] ? e.lanes : 2'b00;
        end
        mem_io_req_ready = e.stall ? 1'($random(seed)) : 1'b1;
        while (n_out < int'(e.exp_cnt) && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
            // Request accepted last edge must sit in the slot now
            if (last_acc >= 0 && mem_io_req !== exp_req[last_acc])
                report_mismatch("mem_io_req", CW'(mem_io_req), CW'(exp_req[last_acc]));
            if (last_acc >= 0 && mem_io_req_valid !== e.lanes)
                report_mismatch("mem_io_req_valid", CW'(mem_io_req_valid), CW'(e.lanes));
            if (held && mem_io_req !== held_req)
                report_mismatch("mem_io_req under stall", CW'(mem_io_req), CW'(held_req));
            if ((|mem_io_req_valid) && !mem_io_req_ready && (|cl_io_req_ready))
                report_error("cluster ready raised while the slot is stalled");
            last_acc = -1;
            held     = (|mem_io_req_valid) && !mem_io_req_ready;
            held_req = mem_io_req;
            if ((|mem_io_req_valid) && mem_io_req_ready) begin
                if (mem_io_req.tag[`MEM_TAG_WIDTH-1 -: `CLUSTER_BITS] !==
                    e.exp_order[2*n_out +: 2])
                    report_mismatch("mem_io_req.tag cluster",
                                    CW'(mem_io_req.tag), CW'(e.exp_order[2*n_out +: 2]));
                n_out++;
            end
            for (int i = 0; i < `NUM_CLUSTERS; i++) begin
                if (pending[i] && cl_io_req_ready[i]) begin
                    if (2'(i) !== e.exp_order[2*n_in +: 2])
                        report_mismatch("grant", CW'(i), CW'(e.exp_order[2*n_in +: 2]));
                    n_in++;
                    pending[i] = 1'b0;
                    last_acc   = i;
                end
            end
            @(posedge clk);
            #1;
            for (int i = 0; i < `NUM_CLUSTERS; i++) begin
                if (!pending[i])
                    cl_io_req_valid[i] = '0;
            end
            mem_io_req_ready = e.stall ? 1'($random(seed)) : 1'b1;
        end
        if (n_out < int'(e.exp_cnt))
            report_error("timeout waiting for requests on the memory side");
        mem_io_req_ready = 1'b1;
        @(negedge clk);
        if (mem_io_req_valid !== '0)
            report_error("memory side shows a request that was already delivered");
    endtask

    task automatic run_rsp(input entry_t e);
        logic [1:0] k;
        k                = e.exp_order[1:0];
        mem_io_rsp_valid = 1'b1;
        mem_io_rsp       = '{e.exp_data, {k, e.tag}};
        cl_io_rsp_ready  = 4'b1 << k;
        @(negedge clk);
        if (cl_io_rsp_valid !== (4'b1 << k))
            report_mismatch("cl_io_rsp_valid", CW'(cl_io_rsp_valid), CW'(4'b1 << k));
        if (cl_io_rsp.tag !== e.tag)
            report_mismatch("cl_io_rsp.tag", CW'(cl_io_rsp.tag), CW'(e.tag));
        if (cl_io_rsp.data !== e.exp_data)
            report_mismatch("cl_io_rsp.data", CW'(cl_io_rsp.data), CW'(e.exp_data));
        if (mem_io_rsp_ready !== 1'b1)
            report_mismatch("mem_io_rsp_ready", CW'(mem_io_rsp_ready), CW'(1));
        @(posedge clk);
        #1;
        mem_io_rsp_valid = 1'b0;
        cl_io_rsp_ready  = '0;
    endtask

    task automatic run_csr(input entry_t e);
        logic [1:0] k;
        logic [1:0] lid;
        logic       done;
        int         cycles;
        int         delay;
        k   = e.exp_order[1:0];
        lid = e.exp_order[3:2];
        for (int i = 0; i < `NUM_CLUSTERS; i++)
            cl_csr_rsp_data[i] = (2'(i) == k) ? e.exp_data : ~e.exp_data;
        // Other clusters answer too and must be ignored
        cl_csr_rsp_valid = ~(4'b1 << k);
        cl_csr_req_ready = '1;
        csr_rsp_ready    = 1'b1;
        csr_req_valid    = 1'b1;
        csr_req_coreid   = e.coreid;
        csr_req          = '{e.addr[11:0], 1'b1, 32'($random(seed))};
        @(negedge clk);
        if (cl_csr_req_valid !== (4'b1 << k))
            report_mismatch("cl_csr_req_valid", CW'(cl_csr_req_valid), CW'(4'b1 << k));
        if (cl_csr_coreid !== lid)
            report_mismatch("cl_csr_coreid", CW'(cl_csr_coreid), CW'(lid));
        if (cl_csr_req !== csr_req)
            report_mismatch("cl_csr_req", CW'(cl_csr_req), CW'(csr_req));
        if (csr_req_ready !== 1'b1)
            report_mismatch("csr_req_ready", CW'(csr_req_ready), CW'(1));
        if (csr_rsp_valid !== 1'b0)
            report_mismatch("csr_rsp_valid", CW'(csr_rsp_valid), CW'(0));
        delay  = 1 + ($random(seed) & 3);
        cycles = 0;
        done   = 1'b0;
        @(posedge clk);
        #1;
        while (!done && cycles < TIMEOUT) begin
            if (cycles == delay)
                cl_csr_rsp_valid = 4'b1 << k;
            @(negedge clk);
            if (csr_req_ready !== 1'b0)
                report_error("second CSR request was accepted while one is in flight");
            if (csr_rsp_valid !== (cycles >= delay))
                report_mismatch("csr_rsp_valid", CW'(csr_rsp_valid), CW'(cycles >= delay));
            if (csr_rsp_valid && csr_rsp_data !== e.exp_data)
                report_mismatch("csr_rsp_data", CW'(csr_rsp_data), CW'(e.exp_data));
            if (csr_rsp_valid && cl_csr_rsp_ready !== (4'b1 << k))
                report_mismatch("cl_csr_rsp_ready", CW'(cl_csr_rsp_ready), CW'(4'b1 << k));
            done = csr_rsp_valid;
            cycles++;
            @(posedge clk);
            #1;
        end
        if (!done)
            report_error("timeout waiting for the CSR response");
        cl_csr_rsp_valid = '0;
        @(negedge clk);
        if (csr_req_ready !== 1'b1)
            report_error("second CSR request not accepted after the response");
        @(posedge clk);
        #1;
        // Close the second request
        csr_req_valid    = 1'b0;
        cl_csr_rsp_valid = 4'b1 << k;
        @(negedge clk);
        if (csr_rsp_valid !== 1'b1)
            report_mismatch("csr_rsp_valid", CW'(csr_rsp_valid), CW'(1));
        @(posedge clk);
        #1;
        cl_csr_rsp_valid = '0;
    endtask

    task automatic run_status(input entry_t e);
        cl_busy   = e.mask;
        cl_ebreak = e.aux;
        @(negedge clk);
        if (busy !== e.exp_data[1])
            report_mismatch("busy", CW'(busy), CW'(e.exp_data[1]));
        if (ebreak !== e.exp_data[0])
            report_mismatch("ebreak", CW'(ebreak), CW'(e.exp_data[0]));
    endtask

    initial begin
        int cycles;
        int start_errors;
        seed             = 46;
        errors           = 0;
        tests_failed     = 0;
        cl_io_req_valid  = '0;
        cl_io_req        = '0;
        cl_io_rsp_ready  = '0;
        mem_io_req_ready = 1'b0;
        mem_io_rsp_valid = 1'b0;
        mem_io_rsp       = '0;
        csr_req_valid    = 1'b0;
        csr_req_coreid   = '0;
        csr_req          = '0;
        csr_rsp_ready    = 1'b0;
        cl_csr_req_ready = '0;
        cl_csr_rsp_valid = '0;
        cl_csr_rsp_data  = '0;
        cl_busy          = '0;
        cl_ebreak        = '0;

        // Round-robin entries run while priority still starts at cluster 0
        tbl[0] = '{KIND_IO, 4'b1111, 4'h0, 2'b01, 30'h200, 8'h10, 4'd0, 1'b0, 3'd4, 8'he4, 32'h0};
        tbl[1] = '{KIND_IO, 4'b1010, 4'h0, 2'b10, 30'h300, 8'h20, 4'd0, 1'b0, 3'd2, 8'h0d, 32'h0};
        tbl[2] = '{KIND_IO, 4'b1111, 4'h0, 2'b11, 30'h400, 8'h30, 4'd0, 1'b1, 3'd4, 8'he4, 32'h0};
        tbl[3] = '{KIND_IO, 4'b0100, 4'h0, 2'b11, 30'h100, 8'h5a, 4'd0, 1'b0, 3'd1, 8'h02, 32'h0};
        tbl[4] = '{KIND_RSP, 4'h0, 4'h0, 2'b00, 30'h0, 8'h3c, 4'd0, 1'b0, 3'd0, 8'h01, 32'hcafe0001};
        tbl[5] = '{KIND_RSP, 4'h0, 4'h0, 2'b00, 30'h0, 8'hc5, 4'd0, 1'b0, 3'd0, 8'h03, 32'h1234abcd};
        // Core id 13 goes to cluster 3 as local core 1
        tbl[6] = '{KIND_CSR, 4'h0, 4'h0, 2'b00, 30'h7c0, 8'h0, 4'd13, 1'b0, 3'd0, 8'h07, 32'hdeadbeef};
        tbl[7] = '{KIND_STATUS, 4'b0000, 4'b1111, 2'b00, 30'h0, 8'h0, 4'd0, 1'b0, 3'd0, 8'h0, 32'h1};
        tbl[8] = '{KIND_STATUS, 4'b0100, 4'b1011, 2'b00, 30'h0, 8'h0, 4'd0, 1'b0, 3'd0, 8'h0, 32'h2};
        tbl[9] = '{KIND_STATUS, 4'b1111, 4'b0000, 2'b00, 30'h0, 8'h0, 4'd0, 1'b0, 3'd0, 8'h0, 32'h2};

        cycles = 0;
        while (arst_n !== 1'b1 && cycles < TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        if (arst_n !== 1'b1)
            report_error("reset was never released");

        for (int t = 0; t < NUM_ENTRIES; t++) begin
            start_errors = errors;
            @(posedge clk);
            #1;
            case (tbl[t].kind)
                KIND_IO:  run_io(tbl[t]);
                KIND_RSP: run_rsp(tbl[t]);
                KIND_CSR: run_csr(tbl[t]);
                default:  run_status(tbl[t]);
            endcase
            if (errors == start_errors) begin
                $display("test %0d (%s) passed", t, kind_name[tbl[t].kind]);
            end else begin
                $display("test %0d (%s) failed", t, kind_name[tbl[t].kind]);
                tests_failed++;
            end
        end

        $display("%0d of %0d tests passed, %0d errors", NUM_ENTRIES - tests_failed,
                 NUM_ENTRIES, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- flist.f
+incdir+src
src/fabric_pkg.sv
src/io_arb.sv
src/csr_io_router.sv
src/fabric_top.sv
verification/tb_clock_gen.sv
verification/tb_fabric.sv

//--- run.sh
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing -f flist.f --top-module tb_fabric -o sim_fabric

./obj_dir/sim_fabric | tee sim.log

if grep -q "TEST RESULT: FAIL" sim.log; then
    echo "Simulation failed, see sim.log"
    exit 1
fi

echo "Simulation passed"
